//--- logic/ppc_mul_pkg.sv
// PowerPC multiply path definitions
`default_nettype none

package ppc_mul_pkg;

    // Architectural widths
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Multiply decode, set by the dispatcher per instruction
    typedef struct packed {
        logic mul_signed;
        logic mul_higher;   // mulhw/mulhwu select bits 63..32
        logic alter_OV;
        logic alter_CR0;
    } mul_decode_t;

    // Condition and exception flags that travel with a result
    typedef struct packed {
        logic OV;
        logic OV_valid;
        logic CR0_valid;
    } cond_exception_t;

    // CR0 field, LT in the most significant position
    typedef struct packed {
        logic LT;
        logic GT;
        logic EQ;
        logic SO;
    } cr0_t;

    // Signed compare of a result against zero, SO copied from XER
    function automatic cr0_t cr0_from_result(
        input logic [0:DATA_WIDTH-1] value,
        input logic                  so
    );
        cr0_t cr0;
        cr0.LT = value[0];
        cr0.GT = ~value[0] & (|value[1:DATA_WIDTH-1]);
        cr0.EQ = ~(|value);
        cr0.SO = so;
        return cr0;
    endfunction

endpackage

`default_nettype wire

//--- logic/mul_issue_queue.sv
// Multiply issue queue
`default_nettype none

module mul_issue_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int TAG_WIDTH   = 5
) (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic                                     disp_valid,
    input  logic [0:TAG_WIDTH-1]                     disp_tag,
    input  logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   disp_reg_addr,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       disp_op1,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       disp_op2,
    input  ppc_mul_pkg::mul_decode_t                 disp_control,
    output logic                                     credit_return,

    output logic                                     issue_valid,
    input  logic                                     issue_ready,
    output logic [0:TAG_WIDTH-1]                     issue_tag,
    output logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   issue_reg_addr,
    output logic [0:ppc_mul_pkg::DATA_WIDTH-1]       issue_op1,
    output logic [0:ppc_mul_pkg::DATA_WIDTH-1]       issue_op2,
    output ppc_mul_pkg::mul_decode_t                 issue_control
);

    import ppc_mul_pkg::*;

    localparam int PTR_WIDTH   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // Entry storage, one slot per dispatch credit
    logic [0:TAG_WIDTH-1]      tag_mem      [QUEUE_DEPTH];
    logic [0:REG_ADDR_WIDTH-1] reg_addr_mem [QUEUE_DEPTH];
    logic [0:DATA_WIDTH-1]     op1_mem      [QUEUE_DEPTH];
    logic [0:DATA_WIDTH-1]     op2_mem      [QUEUE_DEPTH];
    mul_decode_t               control_mem  [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0]      wr_ptr_ff;
    logic [PTR_WIDTH-1:0]      rd_ptr_ff;
    logic [COUNT_WIDTH-1:0]    count_ff;
    logic                      issue_fire;

    // Pointer advance, wraps for depths that are not a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_WIDTH'(1);
    endfunction

    // Oldest entry is visible as soon as the count is nonzero
    assign issue_valid    = (count_ff != '0);
    assign issue_fire     = issue_valid & issue_ready;
    assign credit_return  = issue_fire;

    assign issue_tag      = tag_mem[rd_ptr_ff];
    assign issue_reg_addr = reg_addr_mem[rd_ptr_ff];
    assign issue_op1      = op1_mem[rd_ptr_ff];
    assign issue_op2      = op2_mem[rd_ptr_ff];
    assign issue_control  = control_mem[rd_ptr_ff];

    // Space is guaranteed by the credits held on the dispatch side
    always_ff @(posedge clk) begin
        if (disp_valid) begin
            tag_mem[wr_ptr_ff]      <= disp_tag;
            reg_addr_mem[wr_ptr_ff] <= disp_reg_addr;
            op1_mem[wr_ptr_ff]      <= disp_op1;
            op2_mem[wr_ptr_ff]      <= disp_op2;
            control_mem[wr_ptr_ff]  <= disp_control;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_ff <= '0;
            rd_ptr_ff <= '0;
            count_ff  <= '0;
        end else begin
            if (disp_valid) begin
                wr_ptr_ff <= next_ptr(wr_ptr_ff);
            end

            if (issue_fire) begin
                rd_ptr_ff <= next_ptr(rd_ptr_ff);
            end

            // Simultaneous write and issue leave the count unchanged
            if (disp_valid && !issue_fire) begin
                count_ff <= count_ff + COUNT_WIDTH'(1);
            end else if (!disp_valid && issue_fire) begin
                count_ff <= count_ff - COUNT_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_unit.sv
// Four-stage integer multiplier
`default_nettype none

module mul_unit #(
    parameter int TAG_WIDTH = 5
) (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic                                     input_valid,
    output logic                                     input_ready,
    input  logic [0:TAG_WIDTH-1]                     tag_in,
    input  logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   result_reg_addr_in,

    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       op1,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       op2,
    input  ppc_mul_pkg::mul_decode_t                 control,

    output logic                                     output_valid,
    input  logic                                     output_ready,
    output logic [0:TAG_WIDTH-1]                     tag_out,
    output logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   result_reg_addr_out,

    output logic [0:ppc_mul_pkg::DATA_WIDTH-1]       result,
    output ppc_mul_pkg::cond_exception_t             cr0_xer
);

    import ppc_mul_pkg::*;

    localparam int EXT_WIDTH  = DATA_WIDTH + 1;
    localparam int PROD_WIDTH = 2 * EXT_WIDTH;
    // Index of the low half's MSB in the product
    localparam int LOW_MSB    = PROD_WIDTH - DATA_WIDTH;

    // Per-stage valid bits and sideband
    logic                      valid_ff    [4];
    logic [0:TAG_WIDTH-1]      tag_ff      [4];
    logic [0:REG_ADDR_WIDTH-1] reg_addr_ff [4];
    mul_decode_t               control_ff  [3];
    logic                      stage_en    [4];

    logic [0:DATA_WIDTH-1]     op1_ff;
    logic [0:DATA_WIDTH-1]     op2_ff;
    logic [0:EXT_WIDTH-1]      op1_ext;
    logic [0:EXT_WIDTH-1]      op2_ext;
    logic [0:EXT_WIDTH-1]      op1_ext_ff;
    logic [0:EXT_WIDTH-1]      op2_ext_ff;
    logic [0:PROD_WIDTH-1]     product;
    logic [0:PROD_WIDTH-1]     product_ff;

    logic [0:DATA_WIDTH-1]     result_sel;
    cond_exception_t           flags_sel;
    logic                      sign_span_ones;
    logic                      sign_span_zero;

    // A stage loads when it is empty or its contents move on
    always_comb begin
        stage_en[3] = ~valid_ff[3] | output_ready;
        stage_en[2] = ~valid_ff[2] | stage_en[3];
        stage_en[1] = ~valid_ff[1] | stage_en[2];
        stage_en[0] = ~valid_ff[0] | stage_en[1];
    end

    assign input_ready         = stage_en[0];
    assign output_valid        = valid_ff[3];
    assign tag_out             = tag_ff[3];
    assign result_reg_addr_out = reg_addr_ff[3];

    // Stage 2 operand extension
    assign op1_ext = {control_ff[0].mul_signed & op1_ff[0], op1_ff};
    assign op2_ext = {control_ff[0].mul_signed & op2_ff[0], op2_ff};

    // Stage 3 full product of the extended operands
    assign product = $signed(op1_ext_ff) * $signed(op2_ext_ff);

    // Stage 4 half select and overflow
    always_comb begin
        if (control_ff[2].mul_higher) begin
            result_sel = product_ff[LOW_MSB-DATA_WIDTH:LOW_MSB-1];
        end else begin
            result_sel = product_ff[LOW_MSB:PROD_WIDTH-1];
        end

        // Product fits a signed word only if bits above the low half copy its MSB
        sign_span_ones = &product_ff[0:LOW_MSB];
        sign_span_zero = ~(|product_ff[0:LOW_MSB]);

        flags_sel.OV        = ~(sign_span_ones | sign_span_zero);
        flags_sel.OV_valid  = control_ff[2].alter_OV;
        flags_sel.CR0_valid = control_ff[2].alter_CR0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                valid_ff[i] <= 1'b0;
            end
        end else begin
            if (stage_en[0]) begin
                valid_ff[0] <= input_valid;
            end
            for (int i = 1; i < 4; i++) begin
                if (stage_en[i]) begin
                    valid_ff[i] <= valid_ff[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en[0]) begin
            tag_ff[0]      <= tag_in;
            reg_addr_ff[0] <= result_reg_addr_in;
            control_ff[0]  <= control;
            op1_ff         <= op1;
            op2_ff         <= op2;
        end

        if (stage_en[1]) begin
            tag_ff[1]      <= tag_ff[0];
            reg_addr_ff[1] <= reg_addr_ff[0];
            control_ff[1]  <= control_ff[0];
            op1_ext_ff     <= op1_ext;
            op2_ext_ff     <= op2_ext;
        end

        if (stage_en[2]) begin
            tag_ff[2]      <= tag_ff[1];
            reg_addr_ff[2] <= reg_addr_ff[1];
            control_ff[2]  <= control_ff[1];
            product_ff     <= product;
        end

        if (stage_en[3]) begin
            tag_ff[3]      <= tag_ff[2];
            reg_addr_ff[3] <= reg_addr_ff[2];
            result         <= result_sel;
            cr0_xer        <= flags_sel;
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_writeback.sv
// Multiply writeback and completion
`default_nettype none

module mul_writeback #(
    parameter int TAG_WIDTH = 5
) (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [0:TAG_WIDTH-1]                     in_tag,
    input  logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   in_reg_addr,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       in_result,
    input  ppc_mul_pkg::cond_exception_t             in_flags,

    output logic                                     wb_valid,
    input  logic                                     wb_ready,
    output logic [0:TAG_WIDTH-1]                     wb_tag,
    output logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   wb_reg_addr,
    output logic [0:ppc_mul_pkg::DATA_WIDTH-1]       wb_result,
    output logic                                     wb_ov_write,
    output logic                                     wb_ov,
    output logic                                     wb_so,
    output logic                                     wb_cr0_write,
    output ppc_mul_pkg::cr0_t                        wb_cr0
);

    import ppc_mul_pkg::*;

    logic accept;
    logic so_ff;
    logic so_next;

    // Register accepts when empty or when being drained this cycle
    assign in_ready = ~wb_valid | wb_ready;
    assign accept   = in_valid & in_ready;

    // Sticky summary overflow, only reset clears it
    assign so_next  = so_ff | (in_flags.OV_valid & in_flags.OV);

    // SO changes only on accept, so it always matches the held result
    assign wb_so    = so_ff;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            so_ff    <= 1'b0;
        end else begin
            if (accept) begin
                wb_valid <= 1'b1;
                so_ff    <= so_next;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_tag       <= in_tag;
            wb_reg_addr  <= in_reg_addr;
            wb_result    <= in_result;
            wb_ov_write  <= in_flags.OV_valid;
            wb_ov        <= in_flags.OV;
            wb_cr0_write <= in_flags.CR0_valid;
            wb_cr0       <= cr0_from_result(in_result, so_next);
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_subsystem.sv
// Integer multiply subsystem
`default_nettype none

module mul_subsystem #(
    parameter int QUEUE_DEPTH = 4,
    parameter int TAG_WIDTH   = 5
) (
    input  logic                                     clk,
    input  logic                                     rst,

    // Dispatch, credit based
    input  logic                                     disp_valid,
    input  logic [0:TAG_WIDTH-1]                     disp_tag,
    input  logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   disp_reg_addr,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       disp_op1,
    input  logic [0:ppc_mul_pkg::DATA_WIDTH-1]       disp_op2,
    input  ppc_mul_pkg::mul_decode_t                 disp_control,
    output logic                                     credit_return,

    // Completion
    output logic                                     wb_valid,
    input  logic                                     wb_ready,
    output logic [0:TAG_WIDTH-1]                     wb_tag,
    output logic [0:ppc_mul_pkg::REG_ADDR_WIDTH-1]   wb_reg_addr,
    output logic [0:ppc_mul_pkg::DATA_WIDTH-1]       wb_result,
    output logic                                     wb_ov_write,
    output logic                                     wb_ov,
    output logic                                     wb_so,
    output logic                                     wb_cr0_write,
    output ppc_mul_pkg::cr0_t                        wb_cr0
);

    import ppc_mul_pkg::*;

    // Queue to multiplier
    logic                      issue_valid;
    logic                      issue_ready;
    logic [0:TAG_WIDTH-1]      issue_tag;
    logic [0:REG_ADDR_WIDTH-1] issue_reg_addr;
    logic [0:DATA_WIDTH-1]     issue_op1;
    logic [0:DATA_WIDTH-1]     issue_op2;
    mul_decode_t               issue_control;

    // Multiplier to writeback
    logic                      mul_valid;
    logic                      mul_ready;
    logic [0:TAG_WIDTH-1]      mul_tag;
    logic [0:REG_ADDR_WIDTH-1] mul_reg_addr;
    logic [0:DATA_WIDTH-1]     mul_result;
    cond_exception_t           mul_flags;

    mul_issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .TAG_WIDTH   (TAG_WIDTH)
    ) iq0 (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_tag       (disp_tag),
        .disp_reg_addr  (disp_reg_addr),
        .disp_op1       (disp_op1),
        .disp_op2       (disp_op2),
        .disp_control   (disp_control),
        .credit_return  (credit_return),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_tag      (issue_tag),
        .issue_reg_addr (issue_reg_addr),
        .issue_op1      (issue_op1),
        .issue_op2      (issue_op2),
        .issue_control  (issue_control)
    );

    mul_unit #(
        .TAG_WIDTH (TAG_WIDTH)
    ) mul0 (
        .clk                 (clk),
        .rst                 (rst),
        .input_valid         (issue_valid),
        .input_ready         (issue_ready),
        .tag_in              (issue_tag),
        .result_reg_addr_in  (issue_reg_addr),
        .op1                 (issue_op1),
        .op2                 (issue_op2),
        .control             (issue_control),
        .output_valid        (mul_valid),
        .output_ready        (mul_ready),
        .tag_out             (mul_tag),
        .result_reg_addr_out (mul_reg_addr),
        .result              (mul_result),
        .cr0_xer             (mul_flags)
    );

    mul_writeback #(
        .TAG_WIDTH (TAG_WIDTH)
    ) wb0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (mul_valid),
        .in_ready     (mul_ready),
        .in_tag       (mul_tag),
        .in_reg_addr  (mul_reg_addr),
        .in_result    (mul_result),
        .in_flags     (mul_flags),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_tag       (wb_tag),
        .wb_reg_addr  (wb_reg_addr),
        .wb_result    (wb_result),
        .wb_ov_write  (wb_ov_write),
        .wb_ov        (wb_ov),
        .wb_so        (wb_so),
        .wb_cr0_write (wb_cr0_write),
        .wb_cr0       (wb_cr0)
    );

endmodule

`default_nettype wire

//--- verif/mul_checker.sv
// Multiply subsystem protocol checks
`default_nettype none

module mul_checker #(
    parameter int QUEUE_DEPTH = 4,
    parameter int TAG_WIDTH   = 5
) (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 disp_valid,
    input logic                                 credit_return,
    input logic                                 wb_valid,
    input logic                                 wb_ready,
    input logic [0:TAG_WIDTH-1]                 wb_tag,
    input logic [0:ppc_mul_pkg::DATA_WIDTH-1]   wb_result,
    input ppc_mul_pkg::cr0_t                    wb_cr0
);

    // Entries written to the queue and not yet issued
    int outstanding;

    // Failed assertions so far
    int fail_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(disp_valid) - int'(credit_return);
        end
    end

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        outstanding <= QUEUE_DEPTH)
        else begin
            $error("More multiplies outstanding than queue entries");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        rst |=> (!wb_valid && !credit_return))
        else begin
            $error("Completion or credit active in the cycle after reset");
            fail_count++;
        end

    completion_held: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && !wb_ready) |=>
            (wb_valid && $stable(wb_tag) && $stable(wb_result) && $stable(wb_cr0)))
        else begin
            $error("Completion dropped or changed while stalled");
            fail_count++;
        end

endmodule

bind mul_subsystem mul_checker #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .TAG_WIDTH   (TAG_WIDTH)
) chk0 (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .credit_return (credit_return),
    .wb_valid      (wb_valid),
    .wb_ready      (wb_ready),
    .wb_tag        (wb_tag),
    .wb_result     (wb_result),
    .wb_cr0        (wb_cr0)
);

`default_nettype wire

//--- verif/mul_tb.sv
// Multiply subsystem testbench
`default_nettype none

module mul_tb;

    import ppc_mul_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int TAG_WIDTH   = 5;
    localparam int TIMEOUT     = 2000;

    // One expected completion, in dispatch order
    typedef struct packed {
        logic [0:TAG_WIDTH-1] tag;
        logic [0:4]           reg_addr;
        logic [0:31]          result;
        logic                 ov_write;
        logic                 ov;
        logic                 so;
        logic                 cr0_write;
        logic [0:3]           cr0;
    } expect_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 disp_valid;
    logic [0:TAG_WIDTH-1] disp_tag;
    logic [0:4]           disp_reg_addr;
    logic [0:31]          disp_op1;
    logic [0:31]          disp_op2;
    mul_decode_t          disp_control;
    logic                 credit_return;
    logic                 wb_valid;
    logic                 wb_ready = 1'b1;
    logic [0:TAG_WIDTH-1] wb_tag;
    logic [0:4]           wb_reg_addr;
    logic [0:31]          wb_result;
    logic                 wb_ov_write;
    logic                 wb_ov;
    logic                 wb_so;
    logic                 wb_cr0_write;
    cr0_t                 wb_cr0;

    expect_t              exp_q[$];
    expect_t              head;
    int                   credits;
    logic                 ref_so;
    logic                 stall_mode;
    logic [0:TAG_WIDTH-1] next_tag;

    mul_subsystem #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .TAG_WIDTH   (TAG_WIDTH)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_tag      (disp_tag),
        .disp_reg_addr (disp_reg_addr),
        .disp_op1      (disp_op1),
        .disp_op2      (disp_op2),
        .disp_control  (disp_control),
        .credit_return (credit_return),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_tag        (wb_tag),
        .wb_reg_addr   (wb_reg_addr),
        .wb_result     (wb_result),
        .wb_ov_write   (wb_ov_write),
        .wb_ov         (wb_ov),
        .wb_so         (wb_so),
        .wb_cr0_write  (wb_cr0_write),
        .wb_cr0        (wb_cr0)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            fail_run($sformatf("Error at %0t: %s is %0h, expected %0h",
                               $time, what, got, want));
        end
    endtask

    // Full 64-bit product, half select, overflow range check and sticky SO
    function automatic expect_t ref_mul(input logic [31:0] a, input logic [31:0] b,
                                        input mul_decode_t ctrl, input logic so_in);
        expect_t         e;
        longint          sprod;
        longint unsigned uprod;
        logic [63:0]     prod;
        logic [31:0]     res;
        logic            ov;
        sprod = longint'($signed(a)) * longint'($signed(b));
        uprod = {32'd0, a} * {32'd0, b};
        if (ctrl.mul_signed) begin
            prod = sprod;
            ov   = (sprod > 64'sd2147483647) || (sprod < -64'sd2147483648);
        end else begin
            prod = uprod;
            ov   = uprod > 64'd2147483647;
        end
        res          = ctrl.mul_higher ? prod[63:32] : prod[31:0];
        e            = '0;
        e.result     = res;
        e.ov         = ov;
        e.so         = so_in | (ctrl.alter_OV & ov);
        e.cr0        = {res[31], ~res[31] & (res != 32'd0), res == 32'd0, e.so};
        return e;
    endfunction

    // Dispatcher credit count, one back per credit_return pulse
    always @(posedge clk) begin
        if (rst) begin
            credits <= QUEUE_DEPTH;
        end else begin
            credits <= credits + int'(credit_return) - int'(disp_valid);
        end
    end

    always @(posedge clk) begin
        if (stall_mode) begin
            wb_ready <= ($urandom() % 32'd3) != 32'd0;
        end else begin
            wb_ready <= 1'b1;
        end
    end

    // Protocol assertions of the bound checker
    always @(posedge clk) begin
        assert (dut0.chk0.fail_count == 0) else begin
            fail_run("A protocol assertion in the bound checker failed");
        end
    end

    // Completion scoreboard
    always @(posedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            assert (exp_q.size() > 0) else begin
                fail_run("A completion arrived with no dispatch outstanding");
            end
            head = exp_q.pop_front();
            check_value("tag", 32'(wb_tag), 32'(head.tag));
            check_value("register address", 32'(wb_reg_addr), 32'(head.reg_addr));
            check_value("result", wb_result, head.result);
            check_value("OV", 32'(wb_ov), 32'(head.ov));
            check_value("OV write", 32'(wb_ov_write), 32'(head.ov_write));
            check_value("SO", 32'(wb_so), 32'(head.so));
            check_value("CR0 write", 32'(wb_cr0_write), 32'(head.cr0_write));
            check_value("CR0", 32'(wb_cr0), 32'(head.cr0));
        end
    end

    task automatic dispatch(input logic [31:0] a, input logic [31:0] b, input logic sgn,
                            input logic hi, input logic aov, input logic acr);
        mul_decode_t ctrl;
        expect_t     e;
        int          waited;
        ctrl   = '{mul_signed: sgn, mul_higher: hi, alter_OV: aov, alter_CR0: acr};
        waited = 0;
        @(posedge clk);
        // A dispatch still on the port spends a credit at this edge
        while (credits - int'(disp_valid) <= 0) begin
            disp_valid <= 1'b0;
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("Timeout: no dispatch credit came back from the queue");
            end
            @(posedge clk);
        end
        e             = ref_mul(a, b, ctrl, ref_so);
        e.tag         = next_tag;
        e.reg_addr    = 5'($urandom());
        e.ov_write    = aov;
        e.cr0_write   = acr;
        ref_so        = e.so;
        disp_valid    <= 1'b1;
        disp_tag      <= next_tag;
        disp_reg_addr <= e.reg_addr;
        disp_op1      <= a;
        disp_op2      <= b;
        disp_control  <= ctrl;
        exp_q.push_back(e);
        next_tag      = next_tag + 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            disp_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            disp_valid <= 1'b0;
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("Timeout: completions stopped before all dispatches returned");
            end
        end
        idle_cycles(2);
    endtask

    initial begin
        void'($urandom(32'h1b65));
        rst           = 1'b1;
        disp_valid    = 1'b0;
        disp_tag      = '0;
        disp_reg_addr = '0;
        disp_op1      = '0;
        disp_op2      = '0;
        disp_control  = '0;
        stall_mode    = 1'b0;
        ref_so        = 1'b0;
        next_tag      = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Exact range limits first so SO is still clear, then overflows
        dispatch(32'h7FFF_FFFF, 32'h0000_0001, 1'b1, 1'b0, 1'b1, 1'b1);
        dispatch(32'h8000_0000, 32'h0000_0001, 1'b1, 1'b0, 1'b1, 1'b1);
        dispatch(32'h7FFF_FFFF, 32'h0000_0002, 1'b1, 1'b0, 1'b1, 1'b1);
        dispatch(32'h8000_0000, 32'hFFFF_FFFF, 1'b1, 1'b0, 1'b1, 1'b1);
        dispatch(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b1, 1'b1);
        dispatch(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b1, 1'b1, 1'b1);
        dispatch(32'h0000_0003, 32'h0000_0005, 1'b1, 1'b0, 1'b1, 1'b1);
        // Negative, positive and zero results with mixed alter bits
        dispatch(32'hFFFF_FFFD, 32'h0000_0004, 1'b1, 1'b0, 1'b0, 1'b1);
        dispatch(32'hFFFF_FFFD, 32'h0000_0004, 1'b1, 1'b1, 1'b1, 1'b0);
        dispatch(32'h0000_0003, 32'h0000_0004, 1'b1, 1'b0, 1'b1, 1'b0);
        dispatch(32'h0000_0000, 32'h0000_0007, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_drain();

        for (int i = 0; i < 48; i++) begin
            dispatch($urandom(), $urandom(), i[0], i[1], 1'($urandom()), 1'($urandom()));
        end
        wait_drain();

        stall_mode <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            dispatch($urandom(), $urandom(), i[1], i[0], 1'($urandom()), 1'($urandom()));
        end
        wait_drain();
        stall_mode <= 1'b0;
        idle_cycles(2);

        check_value("credits after drain", 32'(credits), 32'(QUEUE_DEPTH));
        check_value("sticky SO", 32'(wb_so), 32'd1);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/ppc_mul_pkg.sv
logic/mul_issue_queue.sv
logic/mul_unit.sv
logic/mul_writeback.sv
logic/mul_subsystem.sv
verif/mul_checker.sv
verif/mul_tb.sv

//--- Makefile
# Verilator flow for the multiply subsystem

VERILATOR  ?= verilator
TOP        ?= mul_tb
RTL_TOP    ?= mul_subsystem
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= PASS: all tests
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES     := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter logic/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SOURCES) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
